// ==== src/accum_pkg.sv ====
// Accumulator subsystem package
// Shared widths, queue kinds, operation codes and the request format

package accum_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------

  // Operand and running-sum width, fixed for the design
  localparam int DATA_W = 16;

  // --------------------------------------------------
  // Queue kinds
  // --------------------------------------------------

  // Pipe: a full queue takes a new entry while one leaves
  // Bypass: an empty queue hands the entering message straight out
  typedef enum logic [1:0] {
    QUEUE_NORMAL = 2'b00,
    QUEUE_PIPE   = 2'b01,
    QUEUE_BYPASS = 2'b10
  } queue_kind_e;

  // --------------------------------------------------
  // Accumulator requests
  // --------------------------------------------------

  // Three operations, code 2'b11 unused
  typedef enum logic [1:0] {
    OP_ADD   = 2'b00,  // sum += data
    OP_CLEAR = 2'b01,  // sum = 0
    OP_READ  = 2'b10   // sum unchanged
  } accum_op_e;

  // Request payload, op in the upper two bits
  typedef struct packed {
    accum_op_e         op;
    logic [DATA_W-1:0] data;
  } accum_req_t;

endpackage

// ==== src/queue_store.sv ====
// Queue storage
// Entry array with one write port, one combinational read port and an optional bypass mux

module queue_store #(
  parameter type msg_t     = logic,
  parameter int  NUM_MSGS  = 2,
  parameter bit  BYPASS_EN = 1'b0
) (
  input  logic                        clk,
  input  logic                        write_en,
  input  logic [$clog2(NUM_MSGS)-1:0] write_addr,
  input  logic [$clog2(NUM_MSGS)-1:0] read_addr,
  input  logic                        bypass_sel,
  input  msg_t                        enq_msg,
  output msg_t                        deq_msg
);

  // --------------------------------------------------
  // Storage array
  // --------------------------------------------------

  // Payload only, the control side tracks which entries are live
  msg_t mem [NUM_MSGS];
  msg_t read_msg;

  always_ff @(posedge clk) begin
    if (write_en) begin
      mem[write_addr] <= enq_msg;
    end
  end

  // Head of queue, read without a register stage
  assign read_msg = mem[read_addr];

  // --------------------------------------------------
  // Output select
  // --------------------------------------------------

  // Bypass queues show the incoming message while empty
  // BYPASS_EN is a constant, so other kinds reduce to the array read
  assign deq_msg = (BYPASS_EN && bypass_sel) ? enq_msg : read_msg;

endmodule

// ==== src/msg_queue.sv ====
// Multi-entry valid/ready message queue
// Pointer and full-flag control around queue_store, with normal, pipe or bypass behavior

module msg_queue #(
  parameter type                    msg_t    = logic,
  parameter int                     NUM_MSGS = 2,
  parameter accum_pkg::queue_kind_e KIND     = accum_pkg::QUEUE_NORMAL
) (
  input  logic                      clk,
  input  logic                      rst_n,

  // Producer side
  input  logic                      enq_val,
  output logic                      enq_rdy,
  input  msg_t                      enq_msg,

  // Consumer side
  output logic                      deq_val,
  input  logic                      deq_rdy,
  output msg_t                      deq_msg,

  // Free entries, 0 to NUM_MSGS
  output logic [$clog2(NUM_MSGS):0] num_free
);

  localparam int ADDR_W    = $clog2(NUM_MSGS);
  localparam int CNT_W     = ADDR_W + 1;
  localparam bit PIPE_EN   = (KIND == accum_pkg::QUEUE_PIPE);
  localparam bit BYPASS_EN = (KIND == accum_pkg::QUEUE_BYPASS);

  logic [ADDR_W-1:0] enq_ptr;
  logic [ADDR_W-1:0] deq_ptr;
  logic [ADDR_W-1:0] enq_ptr_inc;
  logic [ADDR_W-1:0] deq_ptr_inc;
  logic              full;
  logic              empty;
  logic              do_enq;
  logic              do_deq;
  logic              do_pipe;
  logic              do_bypass;
  logic              write_en;

  // --------------------------------------------------
  // Handshake and status
  // --------------------------------------------------

  assign do_enq = enq_val && enq_rdy;
  assign do_deq = deq_val && deq_rdy;

  // Equal pointers are ambiguous, the full flag settles it
  assign empty = !full && (enq_ptr == deq_ptr);

  // Pipe: full queue refills in the cycle it drains
  assign do_pipe   = PIPE_EN && full && do_enq && do_deq;
  // Bypass: message goes straight through, storage untouched
  assign do_bypass = BYPASS_EN && empty && do_enq && do_deq;

  // Pipe kind lets deq_rdy open the input combinationally
  assign enq_rdy = !full || (PIPE_EN && deq_rdy);
  // Bypass kind lets enq_val show on the output combinationally
  assign deq_val = !empty || (BYPASS_EN && enq_val);

  assign write_en = do_enq && !do_bypass;

  // --------------------------------------------------
  // Pointers and full flag
  // --------------------------------------------------

  // Wrap at NUM_MSGS, which need not be a power of two
  assign enq_ptr_inc = (enq_ptr == ADDR_W'(NUM_MSGS - 1)) ? '0 : enq_ptr + ADDR_W'(1);
  assign deq_ptr_inc = (deq_ptr == ADDR_W'(NUM_MSGS - 1)) ? '0 : deq_ptr + ADDR_W'(1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      enq_ptr <= '0;
      deq_ptr <= '0;
      full    <= 1'b0;
    end else begin
      if (write_en) begin
        enq_ptr <= enq_ptr_inc;
      end
      if (do_deq && !do_bypass) begin
        deq_ptr <= deq_ptr_inc;
      end
      // Fills when the write catches up with the read pointer
      if (do_enq && !do_deq && (enq_ptr_inc == deq_ptr)) begin
        full <= 1'b1;
      end else if (do_deq && full && !do_pipe) begin
        full <= 1'b0;
      end
    end
  end

  // Free count from the pointer distance
  always_comb begin
    if (full) begin
      num_free = '0;
    end else if (enq_ptr >= deq_ptr) begin
      num_free = CNT_W'(NUM_MSGS) - CNT_W'(enq_ptr - deq_ptr);
    end else begin
      num_free = CNT_W'(deq_ptr - enq_ptr);
    end
  end

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------

  queue_store #(
    .msg_t    (msg_t),
    .NUM_MSGS (NUM_MSGS),
    .BYPASS_EN(BYPASS_EN)
  ) store (
    .clk       (clk),
    .write_en  (write_en),
    .write_addr(enq_ptr),
    .read_addr (deq_ptr),
    .bypass_sel(empty),
    .enq_msg   (enq_msg),
    .deq_msg   (deq_msg)
  );

endmodule

// ==== src/accum_unit.sv ====
// Accumulator stage
// Applies add, clear and read requests to a running sum, one response per request

module accum_unit (
  input  logic                           clk,
  input  logic                           rst_n,

  // Requests from the input queue
  input  logic                           in_val,
  output logic                           in_rdy,
  input  accum_pkg::accum_req_t          in_msg,

  // Responses to the output queue
  output logic                           out_val,
  input  logic                           out_rdy,
  output logic [accum_pkg::DATA_W-1:0]   out_data
);

  logic [accum_pkg::DATA_W-1:0] sum;
  logic [accum_pkg::DATA_W-1:0] sum_next;
  logic                         fire;

  // --------------------------------------------------
  // Handshake
  // --------------------------------------------------

  // Pure pass-through of flow control, no internal buffering
  assign in_rdy  = out_rdy;
  assign out_val = in_val;

  // One request consumed and one response produced together
  assign fire = in_val && out_rdy;

  // --------------------------------------------------
  // Sum update
  // --------------------------------------------------

  // Unsigned add, carry out dropped so the sum wraps
  always_comb begin
    case (in_msg.op)
      accum_pkg::OP_ADD:   sum_next = sum + in_msg.data;
      accum_pkg::OP_CLEAR: sum_next = '0;
      accum_pkg::OP_READ:  sum_next = sum;
      default:             sum_next = sum;
    endcase
  end

  // Response is the value the sum takes on this handshake
  assign out_data = sum_next;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum <= '0;
    end else if (fire) begin
      sum <= sum_next;
    end
  end

endmodule

// ==== src/accum_top.sv ====
// Accumulator subsystem top level
// Bypass request queue, accumulator stage and pipe response queue in a chain

module accum_top #(
  parameter int REQ_DEPTH  = 2,
  parameter int RESP_DEPTH = 4
) (
  input  logic                          clk,
  input  logic                          rst_n,

  // Request side
  input  logic                          req_val,
  output logic                          req_rdy,
  input  accum_pkg::accum_op_e          req_op,
  input  logic [accum_pkg::DATA_W-1:0]  req_data,
  output logic [$clog2(REQ_DEPTH):0]    req_free,

  // Response side
  output logic                          resp_val,
  input  logic                          resp_rdy,
  output logic [accum_pkg::DATA_W-1:0]  resp_data
);

  accum_pkg::accum_req_t        req_msg;
  accum_pkg::accum_req_t        in_msg;
  logic                         in_val;
  logic                         in_rdy;
  logic                         out_val;
  logic                         out_rdy;
  logic [accum_pkg::DATA_W-1:0] out_data;

  // Loose request ports into one payload
  assign req_msg.op   = req_op;
  assign req_msg.data = req_data;

  // --------------------------------------------------
  // Input queue, passes through while empty
  // --------------------------------------------------

  msg_queue #(
    .msg_t   (accum_pkg::accum_req_t),
    .NUM_MSGS(REQ_DEPTH),
    .KIND    (accum_pkg::QUEUE_BYPASS)
  ) req_queue (
    .clk     (clk),
    .rst_n   (rst_n),
    .enq_val (req_val),
    .enq_rdy (req_rdy),
    .enq_msg (req_msg),
    .deq_val (in_val),
    .deq_rdy (in_rdy),
    .deq_msg (in_msg),
    .num_free(req_free)
  );

  accum_unit accum (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_val  (in_val),
    .in_rdy  (in_rdy),
    .in_msg  (in_msg),
    .out_val (out_val),
    .out_rdy (out_rdy),
    .out_data(out_data)
  );

  // --------------------------------------------------
  // Output queue, refills while full
  // --------------------------------------------------

  // Free count not needed on this side
  msg_queue #(
    .msg_t   (logic [accum_pkg::DATA_W-1:0]),
    .NUM_MSGS(RESP_DEPTH),
    .KIND    (accum_pkg::QUEUE_PIPE)
  ) resp_queue (
    .clk     (clk),
    .rst_n   (rst_n),
    .enq_val (out_val),
    .enq_rdy (out_rdy),
    .enq_msg (out_data),
    .deq_val (resp_val),
    .deq_rdy (resp_rdy),
    .deq_msg (resp_data),
    .num_free()
  );

endmodule

// ==== testbench/msg_queue_assertions.sv ====
// Queue protocol checks
// Occupancy, free-count and output-valid properties for every msg_queue instance

module msg_queue_assertions #(
  parameter int                     NUM_MSGS = 2,
  parameter accum_pkg::queue_kind_e KIND     = accum_pkg::QUEUE_NORMAL
) (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      enq_val,
  input logic                      enq_rdy,
  input logic                      deq_val,
  input logic                      deq_rdy,
  input logic [$clog2(NUM_MSGS):0] num_free
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CNT_W   = $clog2(NUM_MSGS) + 1;
  localparam bit PIPE_EN = (KIND == accum_pkg::QUEUE_PIPE);

  logic             enq_hs;
  logic             deq_hs;
  logic [CNT_W-1:0] held;

  // --------------------------------------------------
  // Occupancy seen from the ports
  // --------------------------------------------------

  assign enq_hs = enq_val && enq_rdy;
  assign deq_hs = deq_val && deq_rdy;

  // Entries held by the queue
  // A bypass transfer enters and leaves in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      held <= '0;
    end else begin
      held <= held + CNT_W'(enq_hs) - CNT_W'(deq_hs);
    end
  end

  // --------------------------------------------------
  // Occupancy
  // --------------------------------------------------

  // A full queue takes a message only as a pipe queue that is dequeued
  full_enq_a: assert property (@(posedge clk) disable iff (!rst_n)
    !((held == CNT_W'(NUM_MSGS)) && enq_hs) || (PIPE_EN && deq_hs))
    else $error("enqueue handshake on a full queue without a pipe dequeue");

  // Free count bounded by the depth
  free_max_a: assert property (@(posedge clk) disable iff (!rst_n)
    num_free <= CNT_W'(NUM_MSGS))
    else $error("free-entry count above the queue depth");

  // Free count matches the entries held
  free_cnt_a: assert property (@(posedge clk) disable iff (!rst_n)
    num_free == CNT_W'(NUM_MSGS) - held)
    else $error("free-entry count does not match the entries held");

  // --------------------------------------------------
  // Output valid
  // --------------------------------------------------

  deq_known_a: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(deq_val))
    else $error("deq_val unknown after reset");

endmodule

bind msg_queue msg_queue_assertions #(
  .NUM_MSGS(NUM_MSGS),
  .KIND    (KIND)
) queue_checks (
  .clk     (clk),
  .rst_n   (rst_n),
  .enq_val (enq_val),
  .enq_rdy (enq_rdy),
  .deq_val (deq_val),
  .deq_rdy (deq_rdy),
  .num_free(num_free)
);

// ==== testbench/tb_accum.sv ====
// Accumulator subsystem testbench
// Table-driven requests, random response back-pressure, in-order response checks

module tb_accum;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DW         = accum_pkg::DATA_W;
  localparam int TABLE_LEN  = 24;
  localparam int MAX_CYCLES = 20 * TABLE_LEN + 200;
  localparam int RDY_RANDOM = 0;
  localparam int RDY_LOW    = 1;
  localparam int RDY_HIGH   = 2;

  logic                 clk      = 1'b0;
  logic                 resp_rdy = 1'b0;
  logic                 rst_n;
  logic                 req_val;
  logic                 req_rdy;
  accum_pkg::accum_op_e req_op;
  logic [DW-1:0]        req_data;
  logic [1:0]           req_free;
  logic                 resp_val;
  logic [DW-1:0]        resp_data;

  // Stimulus table: op, operand, expected response
  accum_pkg::accum_op_e tab_op   [TABLE_LEN];
  logic [DW-1:0]        tab_data [TABLE_LEN];
  logic [DW-1:0]        tab_exp  [TABLE_LEN];
  int                   tab_fill = 0;

  // Scoreboard, expected responses and their handshake cycles in request order
  logic [DW-1:0] exp_q   [$];
  int            issue_q [$];
  logic [DW-1:0] model_sum = '0;
  logic [DW-1:0] got_exp;
  int            got_issue;
  int            rdy_mode      = RDY_HIGH;
  bit            check_latency = 1'b0;
  integer        seed          = 32'h759603e3;
  integer        rnd;
  int            cycles        = 0;
  int            errors        = 0;
  int            checked       = 0;
  int            tests_run     = 0;
  int            tests_failed  = 0;

  accum_top dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req_op   (req_op),
    .req_data (req_data),
    .req_free (req_free),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp_data(resp_data)
  );

  always #10 clk = ~clk;

  // --------------------------------------------------
  // Reference model and helpers
  // --------------------------------------------------

  // Sum after one request, unsigned with 16-bit wrap
  function automatic logic [DW-1:0] next_sum(input logic [DW-1:0] sum,
                                             input accum_pkg::accum_op_e op,
                                             input logic [DW-1:0] data);
    case (op)
      accum_pkg::OP_ADD:   return sum + data;
      accum_pkg::OP_CLEAR: return '0;
      default:             return sum;
    endcase
  endfunction

  task automatic add_entry(input accum_pkg::accum_op_e op, input logic [DW-1:0] data,
                           input logic [DW-1:0] exp);
    tab_op[tab_fill]   = op;
    tab_data[tab_fill] = data;
    tab_exp[tab_fill]  = exp;
    tab_fill++;
  endtask

  // Holds a request until accepted, then logs its expected response
  task automatic send_req(input accum_pkg::accum_op_e op, input logic [DW-1:0] data,
                          input logic [DW-1:0] exp);
    req_val  <= 1'b1;
    req_op   <= op;
    req_data <= data;
    do begin
      @(posedge clk);
    end while (!req_rdy);
    exp_q.push_back(exp);
    issue_q.push_back(cycles);
  endtask

  // Table rows back to back, each row checked against the model first
  task automatic run_entries(input int first, input int last);
    logic [DW-1:0] model;
    int            i;
    for (i = first; i <= last; i++) begin
      model = next_sum(model_sum, tab_op[i], tab_data[i]);
      assert (model == tab_exp[i]) else begin
        $display("Mismatch at %0t: table entry %0d expects %h, model gives %h",
                 $time, i, tab_exp[i], model);
        errors++;
      end
      model_sum = model;
      send_req(tab_op[i], tab_data[i], tab_exp[i]);
    end
    req_val <= 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    @(posedge clk);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAILED with %0d errors", tests_run, name,
               errors - errors_before);
    end
  endtask

  // --------------------------------------------------
  // Consumer, response checks and resp_rdy
  // --------------------------------------------------

  always @(posedge clk) begin
    if (rst_n && resp_val && resp_rdy) begin
      assert (exp_q.size() != 0) else begin
        $display("Response %h at %0t arrived with no request outstanding", resp_data, $time);
        errors++;
      end
      if (exp_q.size() != 0) begin
        got_exp   = exp_q.pop_front();
        got_issue = issue_q.pop_front();
        checked++;
        assert (resp_data == got_exp) else begin
          $display("Mismatch at %0t: response %h, expected %h", $time, resp_data, got_exp);
          errors++;
        end
        // Only meaningful with empty queues and resp_rdy high
        if (check_latency) begin
          assert (cycles == got_issue + 1) else begin
            $display("Mismatch at %0t: response latency %0d cycles, expected 1",
                     $time, cycles - got_issue);
            errors++;
          end
        end
      end
    end
    rnd = $random(seed);
    case (rdy_mode)
      RDY_RANDOM: resp_rdy <= rnd[0];
      RDY_LOW:    resp_rdy <= 1'b0;
      default:    resp_rdy <= 1'b1;
    endcase
  end

  // Cycle count and run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles before all tests finished", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin : main
    int            errs;
    int            accepted;
    int            i;
    bit            stalled;
    logic [DW-1:0] lat_data;
    rst_n    <= 1'b0;
    req_val  <= 1'b0;
    req_op   <= accum_pkg::OP_ADD;
    req_data <= '0;

    // Adds, wrapping past 16 bits
    add_entry(accum_pkg::OP_ADD,   16'h1234, 16'h1234);
    add_entry(accum_pkg::OP_ADD,   16'h0101, 16'h1335);
    add_entry(accum_pkg::OP_ADD,   16'h7000, 16'h8335);
    add_entry(accum_pkg::OP_ADD,   16'h8000, 16'h0335);
    add_entry(accum_pkg::OP_ADD,   16'hffff, 16'h0334);
    add_entry(accum_pkg::OP_ADD,   16'h0000, 16'h0334);
    add_entry(accum_pkg::OP_ADD,   16'hfccc, 16'h0000);
    add_entry(accum_pkg::OP_ADD,   16'h00ff, 16'h00ff);
    // Clear and read, operand ignored
    add_entry(accum_pkg::OP_READ,  16'habcd, 16'h00ff);
    add_entry(accum_pkg::OP_CLEAR, 16'h5555, 16'h0000);
    add_entry(accum_pkg::OP_READ,  16'h0000, 16'h0000);
    add_entry(accum_pkg::OP_ADD,   16'h0042, 16'h0042);
    add_entry(accum_pkg::OP_READ,  16'hffff, 16'h0042);
    add_entry(accum_pkg::OP_ADD,   16'hffc0, 16'h0002);
    add_entry(accum_pkg::OP_CLEAR, 16'h0000, 16'h0000);
    add_entry(accum_pkg::OP_ADD,   16'h0007, 16'h0007);
    // Mixed, run under random back-pressure
    add_entry(accum_pkg::OP_ADD,   16'h4000, 16'h4007);
    add_entry(accum_pkg::OP_ADD,   16'h4000, 16'h8007);
    add_entry(accum_pkg::OP_READ,  16'h1111, 16'h8007);
    add_entry(accum_pkg::OP_ADD,   16'h8000, 16'h0007);
    add_entry(accum_pkg::OP_ADD,   16'h0ff9, 16'h1000);
    add_entry(accum_pkg::OP_CLEAR, 16'h2222, 16'h0000);
    add_entry(accum_pkg::OP_ADD,   16'hbeef, 16'hbeef);
    add_entry(accum_pkg::OP_READ,  16'h0000, 16'hbeef);

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    errs = errors;
    assert (req_rdy == 1'b1 && resp_val == 1'b0 && req_free == 2'd2) else begin
      $display("Mismatch at %0t: req_rdy %b resp_val %b req_free %0d, expected 1 0 2",
               $time, req_rdy, resp_val, req_free);
      errors++;
    end
    finish_test("reset state", errs);

    errs = errors;
    run_entries(0, 7);
    wait_drain();
    finish_test("wrapping adds", errs);

    errs = errors;
    run_entries(8, 15);
    wait_drain();
    finish_test("clear and read", errs);

    errs = errors;
    rdy_mode = RDY_RANDOM;
    run_entries(16, 23);
    wait_drain();
    finish_test("random back-pressure", errs);

    // Output queue fills, then the input queue, then req_rdy drops
    errs = errors;
    rdy_mode = RDY_LOW;
    repeat (2) @(posedge clk);
    accepted = 0;
    stalled  = 1'b0;
    req_val  <= 1'b1;
    req_op   <= accum_pkg::OP_ADD;
    req_data <= 16'h0111;
    while (!stalled) begin
      @(posedge clk);
      if (req_rdy) begin
        model_sum = next_sum(model_sum, accum_pkg::OP_ADD, req_data);
        exp_q.push_back(model_sum);
        issue_q.push_back(cycles);
        accepted++;
        req_data <= req_data + 16'h0111;
      end else begin
        stalled = 1'b1;
      end
    end
    assert (accepted == 6 && req_free == 2'd0) else begin
      $display("Mismatch at %0t: %0d requests taken with req_free %0d, expected 6 and 0",
               $time, accepted, req_free);
      errors++;
    end
    // Pending request stays on the port until the stall clears
    rdy_mode = RDY_RANDOM;
    model_sum = next_sum(model_sum, accum_pkg::OP_ADD, req_data);
    send_req(accum_pkg::OP_ADD, req_data, model_sum);
    req_val <= 1'b0;
    wait_drain();
    finish_test("stall and drain", errs);

    errs = errors;
    rdy_mode = RDY_HIGH;
    repeat (2) @(posedge clk);
    check_latency = 1'b1;
    for (i = 0; i < 4; i++) begin
      lat_data  = DW'(i) * 16'h1001 + 16'h0033;
      model_sum = next_sum(model_sum, accum_pkg::OP_ADD, lat_data);
      send_req(accum_pkg::OP_ADD, lat_data, model_sum);
    end
    req_val <= 1'b0;
    wait_drain();
    check_latency = 1'b0;
    finish_test("one-cycle latency", errs);

    $display("Summary: %0d tests, %0d failed, %0d responses checked, %0d errors",
             tests_run, tests_failed, checked, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
src/accum_pkg.sv
src/queue_store.sv
src/msg_queue.sv
src/accum_unit.sv
src/accum_top.sv
testbench/msg_queue_assertions.sv
testbench/tb_accum.sv

// ==== Makefile ====
# Verilator build and run for the accumulator subsystem

VERILATOR ?= verilator
TOP       ?= tb_accum
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= All tests passed!

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard src/*.sv testbench/*.sv)

.PHONY: all run build lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass message
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
